/* include/mips_isa.svh */
// MIPS instruction encodings
`ifndef MIPS_ISA_SVH
`define MIPS_ISA_SVH

// Primary opcodes, bits 31:26
`define OP_RTYPE 6'b000000
`define OP_J     6'b000010
`define OP_JAL   6'b000011
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_ADDIU 6'b001001
`define OP_SLTI  6'b001010
`define OP_SLTIU 6'b001011
`define OP_ANDI  6'b001100
`define OP_ORI   6'b001101
`define OP_XORI  6'b001110
`define OP_LUI   6'b001111
// Not a real MIPS opcode, stops the core
`define OP_HALT  6'b111111

// Function codes under R-type, bits 5:0
`define FN_SLL  6'b000000
`define FN_SRL  6'b000010
`define FN_JR   6'b001000
`define FN_ADDU 6'b100001
`define FN_SUBU 6'b100011
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_XOR  6'b100110
`define FN_NOR  6'b100111
`define FN_SLT  6'b101010
`define FN_SLTU 6'b101011

`endif

/* design/cpu_pipe_pkg.sv */
// Pipeline core types
package cpu_pipe_pkg;

	`include "mips_isa.svh"

	// Data and address width
	localparam int WORD_W = 32;
	// Register index width
	localparam int REG_W = 5;
	// Link register for jal
	localparam logic [REG_W-1:0] RA_REG = 5'd31;

	typedef enum logic [5:0] {
		OP_RTYPE = `OP_RTYPE,
		OP_J     = `OP_J,
		OP_JAL   = `OP_JAL,
		OP_BEQ   = `OP_BEQ,
		OP_BNE   = `OP_BNE,
		OP_ADDIU = `OP_ADDIU,
		OP_SLTI  = `OP_SLTI,
		OP_SLTIU = `OP_SLTIU,
		OP_ANDI  = `OP_ANDI,
		OP_ORI   = `OP_ORI,
		OP_XORI  = `OP_XORI,
		OP_LUI   = `OP_LUI,
		OP_HALT  = `OP_HALT
	} opcode_t;

	typedef enum logic [5:0] {
		FN_SLL  = `FN_SLL,
		FN_SRL  = `FN_SRL,
		FN_JR   = `FN_JR,
		FN_ADDU = `FN_ADDU,
		FN_SUBU = `FN_SUBU,
		FN_AND  = `FN_AND,
		FN_OR   = `FN_OR,
		FN_XOR  = `FN_XOR,
		FN_NOR  = `FN_NOR,
		FN_SLT  = `FN_SLT,
		FN_SLTU = `FN_SLTU
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL
	} aluop_t;

	// Sign is the zero value, so an empty record extends by sign
	typedef enum logic [1:0] {
		EXT_SIGN,
		EXT_ZERO,
		EXT_UPPER
	} ext_t;

	// Instruction formats
	typedef struct packed {
		opcode_t          opcode;
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;
		logic [REG_W-1:0] rd;
		logic [4:0]       shamt;
		funct_t           funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_t          opcode;
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;
		logic [15:0]      imm;
	} i_fmt_t;

	typedef struct packed {
		opcode_t     opcode;
		logic [25:0] target;
	} j_fmt_t;

	// Same word, three readings
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		j_fmt_t j_fmt;
	} instr_u;

	// From the fetch side
	typedef struct packed {
		instr_u            instr;
		logic [WORD_W-1:0] npc;
	} fetch_t;

	typedef struct packed {
		aluop_t alu_op;
		logic   alu_src;
		ext_t   ext_op;
		logic   reg_dst;
		logic   reg_wen;
		logic   beq;
		logic   bne;
		logic   jump;
		logic   jump_reg;
		logic   jal;
		logic   halt;
	} ctrl_t;

	// Decode latch contents
	typedef struct packed {
		ctrl_t             ctrl;
		logic [WORD_W-1:0] port_a;
		logic [WORD_W-1:0] port_b;
		logic [WORD_W-1:0] imm_ext;
		logic [4:0]        shamt;
		logic [REG_W-1:0]  rw;
		logic [WORD_W-1:0] npc;
		logic [WORD_W-1:0] jump_addr;
	} decode_t;

	// Execute latch contents
	typedef struct packed {
		logic [WORD_W-1:0] result;
		logic [REG_W-1:0]  rw;
		logic              reg_wen;
		logic              halt;
		logic              valid;
	} exec_t;

	// Register file write port
	typedef struct packed {
		logic              reg_wen;
		logic [REG_W-1:0]  rw;
		logic [WORD_W-1:0] wdat;
	} writeback_t;

endpackage

/* design/control_unit.sv */
// Instruction control decoder
module control_unit (
	input  cpu_pipe_pkg::opcode_t opcode,
	input  cpu_pipe_pkg::funct_t  funct,
	output cpu_pipe_pkg::ctrl_t   ctrl
);
	import cpu_pipe_pkg::*;

	always_comb begin
		// Anything not matched below stays all zero
		ctrl = '0;
		case (opcode)
			OP_RTYPE: begin
				ctrl.reg_dst = 1'b1;
				ctrl.reg_wen = 1'b1;
				case (funct)
					FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_XOR:  ctrl.alu_op = ALU_XOR;
					FN_NOR:  ctrl.alu_op = ALU_NOR;
					FN_SLT:  ctrl.alu_op = ALU_SLT;
					FN_SLTU: ctrl.alu_op = ALU_SLTU;
					FN_SLL:  ctrl.alu_op = ALU_SLL;
					FN_SRL:  ctrl.alu_op = ALU_SRL;
					FN_JR: begin
						// Register jump, no write
						ctrl.reg_dst  = 1'b0;
						ctrl.reg_wen  = 1'b0;
						ctrl.jump_reg = 1'b1;
					end
					default: ctrl = '0;
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				ctrl.alu_src = 1'b1;
				ctrl.reg_wen = 1'b1;
				ctrl.ext_op  = EXT_SIGN;
				// sltiu still sign extends, compare is unsigned
				ctrl.alu_op  = (opcode == OP_ADDIU) ? ALU_ADD :
					(opcode == OP_SLTI) ? ALU_SLT : ALU_SLTU;
			end
			OP_ANDI, OP_ORI, OP_XORI: begin
				ctrl.alu_src = 1'b1;
				ctrl.reg_wen = 1'b1;
				ctrl.ext_op  = EXT_ZERO;
				ctrl.alu_op  = (opcode == OP_ANDI) ? ALU_AND :
					(opcode == OP_ORI) ? ALU_OR : ALU_XOR;
			end
			OP_LUI: begin
				// rs is zero in the encoding, so add passes the immediate
				ctrl.alu_src = 1'b1;
				ctrl.reg_wen = 1'b1;
				ctrl.ext_op  = EXT_UPPER;
				ctrl.alu_op  = ALU_ADD;
			end
			OP_BEQ, OP_BNE: begin
				ctrl.ext_op = EXT_SIGN;
				ctrl.alu_op = ALU_SUB;
				ctrl.beq    = (opcode == OP_BEQ);
				ctrl.bne    = (opcode == OP_BNE);
			end
			OP_J: ctrl.jump = 1'b1;
			OP_JAL: begin
				ctrl.jump    = 1'b1;
				ctrl.jal     = 1'b1;
				ctrl.reg_wen = 1'b1;
			end
			OP_HALT: ctrl.halt = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

/* design/register_file.sv */
// General purpose register file
module register_file #(
	parameter int WORD_W = cpu_pipe_pkg::WORD_W
) (
	input  logic                           CLK,
	input  logic                           nRST,
	input  logic                           wen,
	input  logic [cpu_pipe_pkg::REG_W-1:0] wsel,
	input  logic [WORD_W-1:0]              wdat,
	input  logic [cpu_pipe_pkg::REG_W-1:0] rsel1,
	input  logic [cpu_pipe_pkg::REG_W-1:0] rsel2,
	output logic [WORD_W-1:0]              rdat1,
	output logic [WORD_W-1:0]              rdat2
);
	import cpu_pipe_pkg::*;

	logic [WORD_W-1:0] regs [2**REG_W];

	// Whole array clears on reset
	// Register 0 is never written, so it stays zero
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < 2**REG_W; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (wsel != '0)) begin
			regs[wsel] <= wdat;
		end
	end

	// No bypass, a write shows up the cycle after the edge
	always_comb begin
		rdat1 = regs[rsel1];
		rdat2 = regs[rsel2];
	end

endmodule

/* design/decode_stage.sv */
// Instruction decode stage
module decode_stage #(
	parameter int WORD_W = cpu_pipe_pkg::WORD_W
) (
	input  logic                     CLK,
	input  logic                     nRST,
	input  cpu_pipe_pkg::fetch_t     fetch,
	input  logic                     ihit,
	input  logic                     freeze,
	input  logic                     flush,
	input  cpu_pipe_pkg::writeback_t wb,
	output cpu_pipe_pkg::decode_t    decode_p
);
	import cpu_pipe_pkg::*;

	instr_u            instr;
	ctrl_t             ctrl;
	logic [WORD_W-1:0] rdat1;
	logic [WORD_W-1:0] rdat2;
	logic [WORD_W-1:0] imm_ext;
	decode_t           decode_n;

	assign instr = fetch.instr;

	control_unit cu_i (
		.opcode(instr.r_fmt.opcode),
		.funct (instr.r_fmt.funct),
		.ctrl  (ctrl)
	);

	// Write port comes back from the result stage
	register_file #(.WORD_W(WORD_W)) rf_i (
		.CLK  (CLK),
		.nRST (nRST),
		.wen  (wb.reg_wen),
		.wsel (wb.rw),
		.wdat (wb.wdat),
		.rsel1(instr.r_fmt.rs),
		.rsel2(instr.r_fmt.rt),
		.rdat1(rdat1),
		.rdat2(rdat2)
	);

	// Immediate widening
	always_comb begin
		case (ctrl.ext_op)
			EXT_ZERO:  imm_ext = {{(WORD_W-16){1'b0}}, instr.i_fmt.imm};
			EXT_UPPER: imm_ext = {instr.i_fmt.imm, {(WORD_W-16){1'b0}}};
			default:   imm_ext = {{(WORD_W-16){instr.i_fmt.imm[15]}}, instr.i_fmt.imm};
		endcase
	end

	// Next decode record
	always_comb begin
		decode_n.ctrl    = ctrl;
		decode_n.port_a  = rdat1;
		decode_n.port_b  = rdat2;
		decode_n.imm_ext = imm_ext;
		decode_n.shamt   = instr.r_fmt.shamt;
		// Link register, then rd for R-type, else rt
		decode_n.rw      = ctrl.jal ? RA_REG :
			ctrl.reg_dst ? instr.r_fmt.rd : instr.r_fmt.rt;
		decode_n.npc     = fetch.npc;
		// Region bits of npc above the word target
		decode_n.jump_addr = {fetch.npc[WORD_W-1:WORD_W-4], instr.j_fmt.target, 2'b00};
	end

	// Flush beats freeze, no ihit loads a bubble
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			decode_p <= '0;
		end else if (flush) begin
			decode_p <= '0;
		end else if (freeze) begin
			decode_p <= decode_p;
		end else if (ihit) begin
			decode_p <= decode_n;
		end else begin
			decode_p <= '0;
		end
	end

endmodule

/* design/execute_stage.sv */
// Execute stage with ALU and branch resolve
module execute_stage #(
	parameter int WORD_W = cpu_pipe_pkg::WORD_W
) (
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  freeze,
	input  cpu_pipe_pkg::decode_t decode_p,
	output cpu_pipe_pkg::exec_t   exec_p,
	output logic                  redirect,
	output logic [WORD_W-1:0]     pc_target
);
	import cpu_pipe_pkg::*;

	logic [WORD_W-1:0] alu_a;
	logic [WORD_W-1:0] alu_b;
	logic [WORD_W-1:0] alu_out;
	logic [WORD_W-1:0] branch_target;
	logic              equal;
	logic              take_branch;
	exec_t             exec_n;

	// Second operand from register or immediate
	assign alu_a = decode_p.port_a;
	assign alu_b = decode_p.ctrl.alu_src ? decode_p.imm_ext : decode_p.port_b;

	always_comb begin
		case (decode_p.ctrl.alu_op)
			ALU_ADD:  alu_out = alu_a + alu_b;
			ALU_SUB:  alu_out = alu_a - alu_b;
			ALU_AND:  alu_out = alu_a & alu_b;
			ALU_OR:   alu_out = alu_a | alu_b;
			ALU_XOR:  alu_out = alu_a ^ alu_b;
			ALU_NOR:  alu_out = ~(alu_a | alu_b);
			ALU_SLT:  alu_out = {{(WORD_W-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
			ALU_SLTU: alu_out = {{(WORD_W-1){1'b0}}, alu_a < alu_b};
			// Shifts move rt by shamt
			ALU_SLL:  alu_out = alu_b << decode_p.shamt;
			ALU_SRL:  alu_out = alu_b >> decode_p.shamt;
			default:  alu_out = '0;
		endcase
	end

	// Branch decision from a plain equality
	assign equal       = (decode_p.port_a == decode_p.port_b);
	assign take_branch = (decode_p.ctrl.beq && equal) || (decode_p.ctrl.bne && !equal);

	// Word offset relative to npc
	assign branch_target = decode_p.npc + {decode_p.imm_ext[WORD_W-3:0], 2'b00};

	always_comb begin
		if (decode_p.ctrl.jump_reg) begin
			pc_target = decode_p.port_a;
		end else if (decode_p.ctrl.jump) begin
			pc_target = decode_p.jump_addr;
		end else begin
			pc_target = branch_target;
		end
	end

	// Held off while the pipe is frozen
	assign redirect = (take_branch || decode_p.ctrl.jump || decode_p.ctrl.jump_reg) && !freeze;

	always_comb begin
		// jal returns the link address
		exec_n.result  = decode_p.ctrl.jal ? decode_p.npc : alu_out;
		exec_n.rw      = decode_p.rw;
		exec_n.reg_wen = decode_p.ctrl.reg_wen;
		exec_n.halt    = decode_p.ctrl.halt;
		// Bubbles and unknown words carry no control bits
		exec_n.valid   = |decode_p.ctrl;
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			exec_p <= '0;
		end else if (!freeze) begin
			exec_p <= exec_n;
		end
	end

endmodule

/* design/result_stage.sv */
// Result latch and writeback
module result_stage #(
	parameter int WORD_W = cpu_pipe_pkg::WORD_W
) (
	input  logic                     CLK,
	input  logic                     nRST,
	input  logic                     freeze,
	input  cpu_pipe_pkg::exec_t      exec_p,
	output cpu_pipe_pkg::writeback_t wb,
	output logic                     halted
);
	import cpu_pipe_pkg::*;

	logic              reg_wen_q;
	logic [REG_W-1:0]  rw_q;
	logic [WORD_W-1:0] wdat_q;

	// Control half of the latch
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			reg_wen_q <= 1'b0;
			rw_q      <= '0;
			halted    <= 1'b0;
		end else if (!freeze) begin
			reg_wen_q <= exec_p.valid && exec_p.reg_wen;
			rw_q      <= exec_p.rw;
			// Sticky until reset
			if (exec_p.valid && exec_p.halt) begin
				halted <= 1'b1;
			end
		end
	end

	// Data half
	always_ff @(posedge CLK) begin
		if (!freeze) begin
			wdat_q <= exec_p.result;
		end
	end

	// A held record writes once, after the freeze lifts
	assign wb.reg_wen = reg_wen_q && !freeze;
	assign wb.rw      = rw_q;
	assign wb.wdat    = wdat_q;

endmodule

/* design/pipeline_core.sv */
// Three stage pipeline core
module pipeline_core #(
	parameter int WORD_W = cpu_pipe_pkg::WORD_W
) (
	input  logic                     CLK,
	input  logic                     nRST,
	input  cpu_pipe_pkg::fetch_t     fetch,
	input  logic                     ihit,
	input  logic                     freeze,
	output cpu_pipe_pkg::writeback_t wb,
	output logic                     redirect,
	output logic [WORD_W-1:0]        pc_target,
	output logic                     halted
);
	import cpu_pipe_pkg::*;

	decode_t decode_p;
	exec_t   exec_p;

	// Redirect flushes the wrong-path word in decode
	decode_stage #(.WORD_W(WORD_W)) decode_i (
		.CLK     (CLK),
		.nRST    (nRST),
		.fetch   (fetch),
		.ihit    (ihit),
		.freeze  (freeze),
		.flush   (redirect),
		.wb      (wb),
		.decode_p(decode_p)
	);

	execute_stage #(.WORD_W(WORD_W)) execute_i (
		.CLK      (CLK),
		.nRST     (nRST),
		.freeze   (freeze),
		.decode_p (decode_p),
		.exec_p   (exec_p),
		.redirect (redirect),
		.pc_target(pc_target)
	);

	// Writeback loops into the decode register file
	result_stage #(.WORD_W(WORD_W)) result_i (
		.CLK   (CLK),
		.nRST  (nRST),
		.freeze(freeze),
		.exec_p(exec_p),
		.wb    (wb),
		.halted(halted)
	);

endmodule

/* verif/pipeline_core_tb.sv */
// Pipeline core testbench
module pipeline_core_tb;
	import cpu_pipe_pkg::*;

	localparam int MAX_LINES    = 64;
	localparam int PERIOD       = 20;
	localparam int RESET_CYCLES = 8;
	// Inputs change this long after the rising edge
	localparam int DRIVE_DLY    = 2;

	logic              CLK;
	logic              nRST;
	fetch_t            fetch;
	logic              ihit;
	logic              freeze;
	writeback_t        wb;
	logic              redirect;
	logic [WORD_W-1:0] pc_target;
	logic              halted;

	// One entry per cycle of stimulus
	string             names [MAX_LINES];
	logic              line_ihit [MAX_LINES];
	logic              line_freeze [MAX_LINES];
	logic [WORD_W-1:0] line_instr [MAX_LINES];
	logic [WORD_W-1:0] line_npc [MAX_LINES];
	// Expected writeback, seen three cycles after the line
	logic              exp_wen [MAX_LINES];
	logic [REG_W-1:0]  exp_rw [MAX_LINES];
	logic [WORD_W-1:0] exp_wdat [MAX_LINES];
	// Expected redirect, seen one cycle after the line
	logic              exp_redir [MAX_LINES];
	logic [WORD_W-1:0] exp_target [MAX_LINES];

	int n_lines;
	int halt_line;
	int line_errs [MAX_LINES];
	int total_errs;
	int reset_errs;
	int tests_ok;
	int tests_bad;
	bit loaded;

	pipeline_core #(.WORD_W(WORD_W)) dut_i (
		.CLK      (CLK),
		.nRST     (nRST),
		.fetch    (fetch),
		.ihit     (ihit),
		.freeze   (freeze),
		.wb       (wb),
		.redirect (redirect),
		.pc_target(pc_target),
		.halted   (halted)
	);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	task automatic check_value(input int line, input string what,
		input logic [WORD_W-1:0] expected, input logic [WORD_W-1:0] actual);
		string tname;
		if (line < 0) begin
			tname = "reset";
		end else begin
			tname = names[line];
		end
		if (actual !== expected) begin
			$display("MISMATCH %0s line %0d %0s: expected %h, actual %h",
				tname, line, what, expected, actual);
			total_errs++;
			if (line < 0) begin
				reset_errs++;
			end else begin
				line_errs[line]++;
			end
		end
	endtask

	task automatic load_stimulus(output bit ok);
		int                fd;
		int                cnt;
		string             text;
		string             nm;
		logic [WORD_W-1:0] f [9];
		ok = 1'b1;
		n_lines = 0;
		halt_line = -1;
		fd = $fopen("verif/core_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file verif/core_stimulus.txt");
			ok = 1'b0;
			return;
		end
		while (ok && !$feof(fd)) begin
			text = "";
			cnt = $fgets(text, fd);
			// Blank and comment lines skipped
			if (cnt > 1 && text.getc(0) != "#") begin
				cnt = $sscanf(text, "%s %h %h %h %h %h %h %h %h %h", nm,
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
				if (cnt != 10) begin
					$display("Malformed stimulus line: %0s", text);
					ok = 1'b0;
				end else if (n_lines == MAX_LINES) begin
					$display("Too many stimulus lines, the limit is %0d", MAX_LINES);
					ok = 1'b0;
				end else begin
					names[n_lines]       = nm;
					line_ihit[n_lines]   = f[0][0];
					line_freeze[n_lines] = f[1][0];
					line_instr[n_lines]  = f[2];
					line_npc[n_lines]    = f[3];
					exp_wen[n_lines]     = f[4][0];
					exp_rw[n_lines]      = f[5][REG_W-1:0];
					exp_wdat[n_lines]    = f[6];
					exp_redir[n_lines]   = f[7][0];
					exp_target[n_lines]  = f[8];
					// First accepted halt word sets the sticky flag later
					if (halt_line < 0 && f[0][0] && f[2][31:26] == OP_HALT) begin
						halt_line = n_lines;
					end
					n_lines++;
				end
			end
		end
		$fclose(fd);
		if (ok && n_lines == 0) begin
			$display("The stimulus file holds no test lines");
			ok = 1'b0;
		end
	endtask

	task automatic drive_line(input int n);
		if (n < n_lines) begin
			ihit        = line_ihit[n];
			freeze      = line_freeze[n];
			fetch.instr = line_instr[n];
			fetch.npc   = line_npc[n];
		end else begin
			ihit   = 1'b0;
			freeze = 1'b0;
			fetch  = '0;
		end
	endtask

	task automatic check_idle();
		check_value(-1, "wb.reg_wen", '0, wb.reg_wen);
		check_value(-1, "redirect", '0, redirect);
		check_value(-1, "halted", '0, halted);
	endtask

	// Redirect of the previous line, writeback of the line three back
	task automatic check_cycle(input int n);
		int r;
		int w;
		int h;
		r = n - 1;
		w = n - 3;
		if (r >= 0 && r < n_lines) begin
			check_value(r, "redirect", exp_redir[r], redirect);
			if (exp_redir[r]) begin
				check_value(r, "pc_target", exp_target[r], pc_target);
			end
		end
		if (w >= 0 && w < n_lines) begin
			check_value(w, "wb.reg_wen", exp_wen[w], wb.reg_wen);
			if (exp_wen[w]) begin
				check_value(w, "wb.rw", exp_rw[w], wb.rw);
				check_value(w, "wb.wdat", exp_wdat[w], wb.wdat);
			end
		end
		// Halt reaches the result latch three edges after it is offered
		if (w >= 0) begin
			h = (w < n_lines) ? w : n_lines - 1;
			check_value(h, "halted", halt_line >= 0 && n >= halt_line + 3, halted);
		end
	endtask

	task automatic report_test(input int first, input int last);
		int errs;
		errs = 0;
		for (int i = first; i <= last; i++) begin
			errs += line_errs[i];
		end
		if (errs == 0) begin
			tests_ok++;
			$display("test %0s: ok over %0d cycles", names[first], last - first + 1);
		end else begin
			tests_bad++;
			$display("test %0s: failed with %0d errors", names[first], errs);
		end
	endtask

	// Reset, every stimulus line, then a second reset
	task automatic run_stimulus();
		int line;
		int first;
		repeat (RESET_CYCLES) @(posedge CLK);
		#DRIVE_DLY nRST = 1'b1;
		@(negedge CLK);
		check_idle();
		first = 0;
		// Six spare cycles drain the pipe and watch halted
		for (int n = 0; n < n_lines + 6; n++) begin
			@(posedge CLK);
			#DRIVE_DLY;
			drive_line(n);
			@(negedge CLK);
			check_cycle(n);
			line = n - 3;
			if (line >= 0 && line < n_lines - 1 && names[line + 1] != names[line]) begin
				report_test(first, line);
				first = line + 1;
			end
		end
		report_test(first, n_lines - 1);
		// Sticky halt clears only on reset
		@(posedge CLK);
		#DRIVE_DLY nRST = 1'b0;
		@(negedge CLK);
		check_idle();
		if (reset_errs == 0) begin
			tests_ok++;
			$display("test reset: ok");
		end else begin
			tests_bad++;
			$display("test reset: failed with %0d errors", reset_errs);
		end
	endtask

	initial begin : main
		bit ok;
		nRST       = 1'b0;
		ihit       = 1'b0;
		freeze     = 1'b0;
		fetch      = '0;
		total_errs = 0;
		reset_errs = 0;
		tests_ok   = 0;
		tests_bad  = 0;
		foreach (line_errs[i]) begin
			line_errs[i] = 0;
		end
		load_stimulus(ok);
		if (ok) begin
			loaded = 1'b1;
			run_stimulus();
		end else begin
			total_errs++;
		end
		$display("%0d tests passed, %0d tests failed, %0d errors",
			tests_ok, tests_bad, total_errs);
		if (total_errs == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Deadline scales with the stimulus length
	initial begin : watchdog
		wait (loaded);
		#((n_lines + 20) * PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", n_lines + 20);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* project.f */
+incdir+include
design/cpu_pipe_pkg.sv
design/control_unit.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/pipeline_core.sv
verif/pipeline_core_tb.sv

/* verif/core_stimulus.txt */
# name ihit freeze instr npc | wb_wen wb_rw wb_wdat (3 cycles on) | redirect pc_target (1 cycle on)
# all fields after the name are hex, one line per cycle
alu    1 0 24010123 00400004 1 01 00000123 0 00000000
alu    1 0 3C028000 00400008 1 02 80000000 0 00000000
alu    1 0 240300F0 0040000C 1 03 000000F0 0 00000000
alu    1 0 34040F0F 00400010 1 04 00000F0F 0 00000000
alu    1 0 00212821 00400014 1 05 00000246 0 00000000
alu    1 0 00223023 00400018 1 06 80000123 0 00000000
alu    1 0 00613824 0040001C 1 07 00000020 0 00000000
alu    1 0 00644025 00400020 1 08 00000FFF 0 00000000
alu    1 0 00244826 00400024 1 09 00000E2C 0 00000000
alu    1 0 00235027 00400028 1 0A FFFFFE0C 0 00000000
alu    1 0 0041582A 0040002C 1 0B 00000001 0 00000000
alu    1 0 0041602B 00400030 1 0C 00000000 0 00000000
alu    1 0 00016900 00400034 1 0D 00001230 0 00000000
alu    1 0 00027202 00400038 1 0E 00800000 0 00000000
imm    1 0 240FFFF0 0040003C 1 0F FFFFFFF0 0 00000000
imm    1 0 31508F0F 00400040 1 10 00008E0C 0 00000000
imm    1 0 34118000 00400044 1 11 00008000 0 00000000
imm    1 0 3C121234 00400048 1 12 12340000 0 00000000
imm    1 0 24000055 0040004C 1 00 00000055 0 00000000
imm    1 0 29F40001 00400050 1 14 00000001 0 00000000
imm    1 0 2DF5FFFF 00400054 1 15 00000001 0 00000000
imm    1 0 389600FF 00400058 1 16 00000FF0 0 00000000
imm    1 0 0000B821 0040005C 1 17 00000000 0 00000000
branch 1 0 10210003 00400060 0 00 00000000 1 0040006C
branch 1 0 24180777 00400064 0 00 00000000 0 00000000
branch 1 0 10230005 00400068 0 00 00000000 0 00000000
branch 1 0 24190888 0040006C 1 19 00000888 0 00000000
branch 1 0 1423FFFE 00400070 0 00 00000000 1 00400068
branch 1 0 241A0999 00400074 0 00 00000000 0 00000000
branch 1 0 14210001 00400078 0 00 00000000 0 00000000
branch 1 0 241B0AAA 0040007C 1 1B 00000AAA 0 00000000
jump   1 0 08100040 00400080 0 00 00000000 1 00400100
jump   1 0 241C0BBB 00400084 0 00 00000000 0 00000000
jump   1 0 02200008 00400088 0 00 00000000 1 00008000
jump   1 0 241D0CCC 0040008C 0 00 00000000 0 00000000
jump   1 0 0C100080 00400090 1 1F 00400090 1 00400200
jump   1 0 241E0DDD 00400094 0 00 00000000 0 00000000
bubble 0 0 240507FF 00400098 0 00 00000000 0 00000000
bubble 0 0 240607FF 0040009C 0 00 00000000 0 00000000
bubble 0 0 240707FF 004000A0 0 00 00000000 0 00000000
freeze 1 0 24140321 004000A4 0 00 00000000 0 00000000
freeze 0 1 00000000 004000A8 0 00 00000000 0 00000000
freeze 0 1 00000000 004000AC 1 14 00000321 0 00000000
freeze 0 0 00000000 004000B0 0 00 00000000 0 00000000
freeze 0 0 00000000 004000B4 0 00 00000000 0 00000000
halt   1 0 FC000000 004000B8 0 00 00000000 0 00000000
halt   0 0 00000000 004000BC 0 00 00000000 0 00000000
halt   0 0 00000000 004000C0 0 00 00000000 0 00000000
